// ==== mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Byte address on the data port
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [DATA_W-1:0] data_t;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Everything at or above this goes out to the peripheral bus
    localparam addr_t PERIPHERAL_BASE = 32'h1000_0000;

    // Character output FIFO, lives inside the cached space
    localparam addr_t EXT_FIFO_ADDR = 32'h0001_0150;

    // Destination of one processor access
    typedef enum logic [1:0] {
        region_cache,
        region_peri,
        region_ext
    } region_e;

endpackage

`default_nettype wire

// ==== access_pkg.sv ====
`default_nettype none

package access_pkg;

    //////////////////////////////
    // Access encodings
    //////////////////////////////

    // Load/store opcode as driven by the core
    typedef enum logic [1:0] {
        acc_idle  = 2'b00,
        acc_read  = 2'b01,
        acc_write = 2'b10,
        acc_flush = 2'b11
    } access_e;

    localparam int BYTE_EN_W = 4;

    // One enable per byte lane of a word
    typedef logic [BYTE_EN_W-1:0] byte_en_t;

    //////////////////////////////
    // Peripheral timing
    //////////////////////////////

    // Shortest transaction, in cycles from acceptance
    localparam int PERI_MIN_CYCLES_DEFAULT = 3;

endpackage

`default_nettype wire

// ==== peri_req_if.sv ====
`default_nettype none

interface peri_req_if
    import mem_map_pkg::*, access_pkg::*;
();

    // Fields are only meaningful while accept is high
    logic     accept;
    logic     write;
    addr_t    addr;
    data_t    wdata;
    byte_en_t wstrb;

    modport decoder (
        output accept,
        output write,
        output addr,
        output wdata,
        output wstrb
    );

    modport sequencer (
        input accept,
        input write,
        input addr,
        input wdata,
        input wstrb
    );

endinterface

`default_nettype wire

// ==== access_decode.sv ====
`default_nettype none

module access_decode
    import mem_map_pkg::*, access_pkg::*;
(
    input  wire logic     CLK,
    input  wire logic     arst_n,
    input  wire logic     enable,

    // Processor load/store port
    input  wire access_e  proc_ctrl,
    input  wire addr_t    proc_addr,
    input  wire data_t    proc_wdata,
    input  wire byte_en_t proc_byte_en,

    input  wire logic     cache_ready,

    // Status from the peripheral sequencer
    input  wire logic     busy,
    input  wire logic     done_pulse,

    output access_e       cache_ctrl,
    output logic          ext_hit,
    output data_t         ext_data,

    peri_req_if.decoder   req
);

    region_e region;
    logic    is_rw;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    always_comb
    begin
        if (proc_addr == EXT_FIFO_ADDR)
            region = region_ext;
        else if (proc_addr >= PERIPHERAL_BASE)
            region = region_peri;
        else
            region = region_cache;
    end

    assign is_rw = (proc_ctrl == acc_read) || (proc_ctrl == acc_write);

    //////////////////////////////
    // Peripheral request
    //////////////////////////////

    // Held off in the completion cycle so the same access is not taken twice
    assign req.accept = is_rw && (region == region_peri) && cache_ready && enable
                        && !busy && !done_pulse;

    assign req.write = (proc_ctrl == acc_write);
    assign req.addr  = proc_addr;
    assign req.wdata = proc_wdata;
    assign req.wstrb = proc_byte_en;

    // Cache only sees its own region, and nothing during a peripheral access
    assign cache_ctrl = ((region == region_cache) && !busy) ? proc_ctrl : acc_idle;

    // Character output, writes only
    assign ext_hit  = (proc_ctrl == acc_write) && (region == region_ext)
                      && cache_ready && enable;
    assign ext_data = proc_wdata;

    // Decoder and sequencer must agree on transaction ownership
    assert property (@(posedge CLK) disable iff (!arst_n)
        req.accept |=> busy)
        else $error("accepted peripheral request not taken by the sequencer");

endmodule

`default_nettype wire

// ==== peri_sequencer.sv ====
`default_nettype none

module peri_sequencer
    import mem_map_pkg::*, access_pkg::*;
#(
    parameter int peri_min_cycles = PERI_MIN_CYCLES_DEFAULT
)
(
    input  wire logic     CLK,
    input  wire logic     arst_n,

    peri_req_if.sequencer req,

    // Peripheral strobe port
    input  wire logic     peri_done,
    output logic          peri_start,
    output logic          peri_write,
    output addr_t         peri_addr,
    output data_t         peri_wdata,
    output byte_en_t      peri_wstrb,

    output logic          busy,
    output logic          done_pulse
);

    // Counter only has to reach peri_min_cycles - 1
    localparam int CNT_W = (peri_min_cycles > 1) ? $clog2(peri_min_cycles) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(peri_min_cycles - 1);

    logic [CNT_W-1:0] cnt;
    logic             done_seen;
    logic             done_now;
    logic             min_met;

    // Done may already be arriving in this cycle
    assign done_now = done_seen | peri_done;
    assign min_met  = (cnt == LAST_CNT);

    //////////////////////////////
    // Transaction control
    //////////////////////////////

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy       <= 1'b0;
            peri_start <= 1'b0;
            done_pulse <= 1'b0;
            done_seen  <= 1'b0;
            cnt        <= '0;
        end
        else
        begin
            peri_start <= req.accept;
            done_pulse <= 1'b0;
            if (req.accept)
            begin
                busy      <= 1'b1;
                done_seen <= 1'b0;
                cnt       <= '0;
            end
            else if (busy)
            begin
                if (done_now && min_met)
                begin
                    busy       <= 1'b0;
                    done_pulse <= 1'b1;
                end
                else
                begin
                    done_seen <= done_now;
                    // Saturate once the minimum length is covered
                    if (!min_met)
                        cnt <= cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Request hold registers
    //////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (req.accept)
        begin
            peri_write <= req.write;
            peri_addr  <= req.addr;
            peri_wdata <= req.wdata;
            peri_wstrb <= req.wstrb;
        end
    end

    // Decoder must never accept in back-to-back cycles
    assert property (@(posedge CLK) disable iff (!arst_n)
        peri_start |=> !peri_start)
        else $error("peri_start not a single-cycle pulse after accept");

endmodule

`default_nettype wire

// ==== read_return.sv ====
`default_nettype none

module read_return
    import mem_map_pkg::*;
(
    input  wire logic  CLK,
    input  wire logic  arst_n,

    // Peripheral read side
    input  wire logic  peri_done,
    input  wire data_t peri_rdata,

    input  wire data_t cache_rdata,
    input  wire logic  done_pulse,

    // Extraction write from the decoder
    input  wire logic  ext_hit,
    input  wire data_t ext_data,

    output data_t      proc_rdata,
    output logic       ext_wr_en,
    output data_t      ext_wr_data
);

    data_t peri_rdata_q;

    //////////////////////////////
    // Load data return
    //////////////////////////////

    // Peripheral data is only valid in the done cycle, keep it until completion
    always_ff @(posedge CLK)
    begin
        if (peri_done)
            peri_rdata_q <= peri_rdata;
    end

    assign proc_rdata = done_pulse ? peri_rdata_q : cache_rdata;

    //////////////////////////////
    // Character output strobe
    //////////////////////////////

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
            ext_wr_en <= 1'b0;
        else
            ext_wr_en <= ext_hit;
    end

    always_ff @(posedge CLK)
    begin
        if (ext_hit)
            ext_wr_data <= ext_data;
    end

    // One character per processor store
    assert property (@(posedge CLK) disable iff (!arst_n)
        ext_wr_en |=> !ext_wr_en)
        else $error("ext_wr_en held for two cycles");

endmodule

`default_nettype wire

// ==== data_port_router.sv ====
`default_nettype none

module data_port_router
    import mem_map_pkg::*, access_pkg::*;
#(
    parameter int peri_min_cycles = PERI_MIN_CYCLES_DEFAULT
)
(
    input  wire logic     CLK,
    input  wire logic     arst_n,
    input  wire logic     enable,

    // Processor data port
    input  wire access_e  proc_ctrl,
    input  wire addr_t    proc_addr,
    input  wire data_t    proc_wdata,
    input  wire byte_en_t proc_byte_en,
    output data_t         proc_rdata,
    output logic          proc_ready,

    // Data cache port
    output access_e       cache_ctrl,
    output addr_t         cache_addr,
    output data_t         cache_wdata,
    output byte_en_t      cache_byte_en,
    input  wire data_t    cache_rdata,
    input  wire logic     cache_ready,

    // Peripheral strobe port
    output logic          peri_start,
    output addr_t         peri_addr,
    output logic          peri_write,
    output data_t         peri_wdata,
    output byte_en_t      peri_wstrb,
    input  wire data_t    peri_rdata,
    input  wire logic     peri_done,

    // Character output FIFO
    output logic          ext_wr_en,
    output data_t         ext_wr_data,

    output logic          fetch_hold
);

    logic  busy;
    logic  done_pulse;
    logic  ext_hit;
    data_t ext_data;

    peri_req_if req_if ();

    // Cache sees the raw request fields, only ctrl is gated
    assign cache_addr    = proc_addr;
    assign cache_wdata   = proc_wdata;
    assign cache_byte_en = proc_byte_en;

    //////////////////////////////
    // Processor handshake
    //////////////////////////////

    assign proc_ready = done_pulse | (cache_ready & !busy);
    assign fetch_hold = busy;

    access_decode u_decode (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .enable       (enable),
        .proc_ctrl    (proc_ctrl),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .cache_ready  (cache_ready),
        .busy         (busy),
        .done_pulse   (done_pulse),
        .cache_ctrl   (cache_ctrl),
        .ext_hit      (ext_hit),
        .ext_data     (ext_data),
        .req          (req_if.decoder)
    );

    peri_sequencer #(
        .peri_min_cycles (peri_min_cycles)
    ) u_sequencer (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .req        (req_if.sequencer),
        .peri_done  (peri_done),
        .peri_start (peri_start),
        .peri_write (peri_write),
        .peri_addr  (peri_addr),
        .peri_wdata (peri_wdata),
        .peri_wstrb (peri_wstrb),
        .busy       (busy),
        .done_pulse (done_pulse)
    );

    read_return u_return (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .peri_done   (peri_done),
        .peri_rdata  (peri_rdata),
        .cache_rdata (cache_rdata),
        .done_pulse  (done_pulse),
        .ext_hit     (ext_hit),
        .ext_data    (ext_data),
        .proc_rdata  (proc_rdata),
        .ext_wr_en   (ext_wr_en),
        .ext_wr_data (ext_wr_data)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 5
)
(
    output logic CLK,
    output logic arst_n
);

    initial
    begin
        CLK = 1'b0;
        forever #half_period CLK = ~CLK;
    end

    // Release just after an edge, well clear of the sampling point
    initial
    begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge CLK);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_data_port_router.sv ====
`default_nettype none

module tb_data_port_router
    import mem_map_pkg::*, access_pkg::*;
;

    typedef enum logic [1:0] {out_cache, out_peri, out_ext, out_none} outcome_e;

    typedef struct packed {
        access_e    op;
        addr_t      addr;
        data_t      wdata;
        logic       rand_wd;
        byte_en_t   be;
        logic       en;
        logic       cready;
        logic [3:0] done_delay;
        data_t      rdata;
        outcome_e   outcome;
    } row_t;

    localparam int NROWS      = 16;
    localparam int MIN_CYCLES = PERI_MIN_CYCLES_DEFAULT;

    logic     CLK;
    logic     arst_n;
    logic     enable;
    access_e  proc_ctrl;
    addr_t    proc_addr;
    data_t    proc_wdata;
    byte_en_t proc_byte_en;
    data_t    proc_rdata;
    logic     proc_ready;
    access_e  cache_ctrl;
    addr_t    cache_addr;
    data_t    cache_wdata;
    byte_en_t cache_byte_en;
    data_t    cache_rdata = '0;
    logic     cache_ready;
    logic     peri_start;
    addr_t    peri_addr;
    logic     peri_write;
    data_t    peri_wdata;
    byte_en_t peri_wstrb;
    data_t    peri_rdata = '0;
    logic     peri_done = 1'b0;
    logic     ext_wr_en;
    data_t    ext_wr_data;
    logic     fetch_hold;

    row_t  rows [NROWS];
    int    cycles = 0;
    int    timeout_limit = 1000;
    int    cur_delay = 0;
    int    done_wait = -1;
    data_t cur_rdata = '0;

    tb_clock_gen #(.half_period(2), .reset_cycles(5)) clk_gen_i (.CLK(CLK), .arst_n(arst_n));

    data_port_router #(.peri_min_cycles(MIN_CYCLES)) dut_i (.*);

    //////////////////////////////
    // Target models
    //////////////////////////////

    function automatic data_t cache_word(input int c);
        return 32'hCA00_0000 ^ (32'(c) * 32'h0001_0003);
    endfunction

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // Peripheral answers cur_delay cycles after its start strobe
    always @(posedge CLK)
    begin
        #1;
        peri_done = 1'b0;
        if (peri_start)
            done_wait = cur_delay;
        else if (done_wait > 0)
            done_wait = done_wait - 1;
        if (done_wait == 0)
        begin
            peri_done = 1'b1;
            done_wait = -1;
        end
        // Junk outside the done cycle
        peri_rdata  = peri_done ? cur_rdata : ~cur_rdata;
        cache_rdata = cache_word(cycles);
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected)
        begin
            $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic drive_request(input access_e op, input addr_t addr, input data_t wdata,
                                 input byte_en_t be, input logic en, input logic cready);
        proc_ctrl    = op;
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = be;
        enable       = en;
        cache_ready  = cready;
    endtask

    task automatic apply_row(input row_t r);
        data_t wd;
        int    low_cycles;
        int    expect_low;
        wd = r.rand_wd ? $urandom() : r.wdata;
        @(posedge CLK);
        #1;
        drive_request(r.op, r.addr, wd, r.be, r.en, r.cready);
        cur_delay = int'(r.done_delay);
        cur_rdata = r.rdata;
        #2;
        if (r.outcome == out_cache)
            check_equal(32'(cache_ctrl), 32'(r.op), "cache_ctrl passes the opcode");
        else
            check_equal(32'(cache_ctrl), 32'(acc_idle), "cache_ctrl idle outside cache");
        check_equal(32'(proc_ready), 32'(r.cready), "proc_ready follows cache_ready");
        check_equal(proc_rdata, cache_word(cycles), "proc_rdata from cache");
        check_equal(cache_addr, r.addr, "cache_addr pass-through");
        check_equal(cache_wdata, wd, "cache_wdata pass-through");
        check_equal(32'(cache_byte_en), 32'(r.be), "cache_byte_en pass-through");
        check_equal(32'(fetch_hold), 32'(0), "fetch_hold low while idle");

        // Processor keeps a peripheral request up until it completes
        @(posedge CLK);
        #1;
        if (r.outcome != out_peri)
            drive_request(acc_idle, '0, '0, '0, 1'b1, 1'b1);
        #2;
        check_equal(32'(peri_start), 32'(r.outcome == out_peri), "peri_start after row");
        check_equal(32'(ext_wr_en), 32'(r.outcome == out_ext), "ext_wr_en after row");
        if (r.outcome == out_ext)
            check_equal(ext_wr_data, wd, "ext_wr_data");
        if (r.outcome != out_peri)
            return;

        check_equal(32'(peri_write), 32'(r.op == acc_write), "peri_write");
        check_equal(32'(peri_wstrb), 32'(r.be), "peri_wstrb");
        if (r.op == acc_write)
            check_equal(peri_wdata, wd, "peri_wdata");
        low_cycles = 0;
        while (proc_ready == 1'b0)
        begin
            if (low_cycles > 0)
                check_equal(32'(peri_start), 32'(0), "peri_start lasts one cycle");
            check_equal(peri_addr, r.addr, "peri_addr held");
            check_equal(32'(cache_ctrl), 32'(acc_idle), "cache_ctrl idle while busy");
            check_equal(32'(fetch_hold), 32'(1), "fetch_hold while busy");
            check_equal(proc_rdata, cache_word(cycles), "proc_rdata before completion");
            low_cycles++;
            @(posedge CLK);
            #3;
        end
        // Ends at the later of done seen and the minimum length
        expect_low = (cur_delay + 1 > MIN_CYCLES) ? cur_delay + 1 : MIN_CYCLES;
        check_equal(32'(low_cycles), 32'(expect_low), "cycles with proc_ready low");
        check_equal(32'(fetch_hold), 32'(0), "fetch_hold at completion");
        check_equal(32'(peri_start), 32'(0), "no second peri_start");
        if (r.op == acc_read)
            check_equal(proc_rdata, r.rdata, "peripheral read data");
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        int max_delay;
        max_delay = 0;
        void'($urandom(71909));
        drive_request(acc_idle, '0, '0, '0, 1'b0, 1'b1);
        rows = '{
            // op, addr, wdata, random, be, enable, cache_ready, done delay, rdata, outcome
            '{acc_read,  32'h0000_1000, 32'h0, 1'b0, 4'hF, 1'b1, 1'b1, 4'd0, 32'h0, out_cache},
            '{acc_write, 32'h0000_2004, 32'h0, 1'b1, 4'hF, 1'b1, 1'b1, 4'd0, 32'h0, out_cache},
            '{acc_read,  32'h0000_3008, 32'h0, 1'b0, 4'hF, 1'b1, 1'b0, 4'd0, 32'h0, out_cache},
            '{acc_flush, 32'h0000_0040, 32'h0, 1'b0, 4'h0, 1'b1, 1'b1, 4'd0, 32'h0, out_cache},
            '{acc_write, 32'h1000_0010, 32'h0, 1'b1, 4'h3, 1'b1, 1'b1, 4'd4, 32'h0, out_peri},
            '{acc_read,  32'h1000_0020, 32'h0, 1'b0, 4'hF, 1'b1, 1'b1, 4'd2, 32'hDEAD_BEEF,
              out_peri},
            '{acc_read,  32'h1000_0100, 32'h0, 1'b0, 4'hF, 1'b1, 1'b1, 4'd0, 32'h1234_5678,
              out_peri},
            '{acc_write, 32'h2000_0000, 32'hA5A5_0F0F, 1'b0, 4'hC, 1'b1, 1'b1, 4'd6, 32'h0,
              out_peri},
            '{acc_write, EXT_FIFO_ADDR, 32'h0, 1'b1, 4'h1, 1'b1, 1'b1, 4'd0, 32'h0, out_ext},
            '{acc_read,  EXT_FIFO_ADDR, 32'h0, 1'b0, 4'hF, 1'b1, 1'b1, 4'd0, 32'h0, out_none},
            '{acc_write, 32'h1000_0030, 32'h1111_2222, 1'b0, 4'hF, 1'b0, 1'b1, 4'd1, 32'h0,
              out_none},
            '{acc_read,  32'h1000_0040, 32'h0, 1'b0, 4'hF, 1'b1, 1'b0, 4'd1, 32'h0, out_none},
            '{acc_write, EXT_FIFO_ADDR, 32'h41, 1'b0, 4'h1, 1'b0, 1'b1, 4'd0, 32'h0, out_none},
            '{acc_write, EXT_FIFO_ADDR, 32'h42, 1'b0, 4'h1, 1'b1, 1'b0, 4'd0, 32'h0, out_none},
            '{acc_idle,  32'h1000_0050, 32'h0, 1'b0, 4'hF, 1'b1, 1'b1, 4'd0, 32'h0, out_none},
            '{acc_read,  32'h0FFF_FFFC, 32'h0, 1'b0, 4'hF, 1'b1, 1'b1, 4'd0, 32'h0, out_cache}
        };
        foreach (rows[i])
            if (int'(rows[i].done_delay) > max_delay)
                max_delay = int'(rows[i].done_delay);
        timeout_limit = NROWS * (max_delay + MIN_CYCLES + 4);

        wait (arst_n === 1'b1);
        check_equal(32'(peri_start), 32'(0), "peri_start low after reset");
        check_equal(32'(ext_wr_en), 32'(0), "ext_wr_en low after reset");
        check_equal(32'(fetch_hold), 32'(0), "fetch_hold low after reset");
        for (int i = 0; i < NROWS; i++)
            apply_row(rows[i]);
        @(posedge CLK);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
mem_map_pkg.sv
access_pkg.sv
peri_req_if.sv
access_decode.sv
peri_sequencer.sv
read_return.sv
data_port_router.sv
tb_clock_gen.sv
tb_data_port_router.sv

// ==== Makefile ====
SOURCES := $(shell cat compile.f)

all: run

obj_dir/Vtb_data_port_router: compile.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_data_port_router -f compile.f

run: obj_dir/Vtb_data_port_router
	./obj_dir/Vtb_data_port_router | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
